//--- Bender.yml
package:
  name: fetch_subsystem

sources:
  - hdl/cache_pkg.sv
  - hdl/bus_pkg.sv
  - hdl/fetch_port.sv
  - hdl/icache_core.sv
  - hdl/line_refill.sv
  - hdl/fetch_subsystem.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/tb_memory.sv
      - bench/tb_fetch.sv

//--- bench/tb_clock.sv
// ================================================
// bench clock and power-on reset
// ================================================
module tb_clock #(
	parameter int period       = 4,
	parameter int reset_cycles = 8
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	// released just after an edge, like every other input
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		#1;
		reset = 1'b0;
	end

endmodule

//--- bench/tb_fetch.sv
// ================================================
// fetch path bench running directed and random
// fetches against a tag model and the DRAM word rule
// ================================================
module tb_fetch;
	import cache_pkg::*;
	import bus_pkg::*;

	localparam int clock_period     = 4;
	localparam int reset_cycles     = 8;
	localparam int directed_fetches = 23;
	localparam int random_fetches   = 300;
	localparam int total_fetches    = directed_fetches + random_fetches;
	localparam int watchdog_time    = (total_fetches * 200 + reset_cycles + 100) * clock_period;

	localparam word_addr_t line_a = 30'h0001_2340;
	localparam word_addr_t line_b = 30'h0003_2340;  // same index bits, other tag
	localparam word_addr_t line_c = 30'h0ABC_DE00;  // random window base

	logic        clock;
	logic        reset;
	logic        fetch_valid;
	word_addr_t  fetch_addr;
	logic        fetch_fence;
	logic        fetch_ready;
	instr_t      fetch_data;
	logic        mem_sel;
	byte_addr_t  mem_addr;
	burst_len_t  mem_len;
	burst_size_t mem_size;
	logic        mem_rvalid;
	logic        mem_rlast;
	beat_t       mem_rdata;

	tag_t model_tag [cache_lines];
	bit   model_valid [cache_lines];

	bit          in_flight;
	word_addr_t  pend_addr;
	bit          pend_hit;
	int          strobe_cycle;
	int          bursts;        // mem_sel bursts of the current fetch
	bit          sel_seen;
	int          cycle_count;
	logic [15:0] lfsr = 16'd54412;

	tb_clock #(.period(clock_period), .reset_cycles(reset_cycles)) clock_gen (.*);
	tb_memory dram (.*);
	fetch_subsystem uut (.*);

	always @(posedge clock)
		cycle_count <= cycle_count + 1;

	function automatic logic lfsr_bit();
		logic out;
		out  = lfsr[0];
		lfsr = lfsr >> 1;
		if (out)
			lfsr = lfsr ^ 16'hB400;
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		repeat (n)
			r = {r[30:0], lfsr_bit()};
		return r;
	endfunction

	// reference for the DRAM word at byte address a
	function automatic instr_t mem_word(input byte_addr_t a);
		return a ^ 32'h5A5A0000;
	endfunction

	// predicts hit or miss, then records the line as a refill would
	function automatic bit model_access(input word_addr_t addr);
		line_idx_t idx;
		tag_t      tag;
		bit        hit;
		idx = addr[2:1];
		tag = addr[29:3];
		hit = model_valid[idx] && (model_tag[idx] == tag);
		model_valid[idx] = 1'b1;
		model_tag[idx]   = tag;
		return hit;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_instr(input instr_t got, input instr_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s got %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_addr(input byte_addr_t got, input byte_addr_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s got %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_len(input burst_len_t got, input burst_len_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s got %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic check_size(input burst_size_t got, input burst_size_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s got %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic check_hit(input bit got, input bit exp, input string what);
		if (got !== exp)
			abort_run($sformatf("Error at %0t: %s got hit=%0b, expected hit=%0b",
				$time, what, got, exp));
	endtask

	task automatic check_latency(input int got, input int exp, input string what);
		if (got != exp)
			abort_run($sformatf("Error at %0t: %s got %0d cycles, expected %0d",
				$time, what, got, exp));
	endtask

	task automatic do_fetch(input word_addr_t addr);
		@(posedge clock);
		#1;
		pend_addr    = addr;
		pend_hit     = model_access(addr);
		strobe_cycle = cycle_count;
		bursts       = 0;
		in_flight    = 1'b1;
		fetch_valid  = 1'b1;
		fetch_addr   = addr;
		@(posedge clock);
		#1;
		fetch_valid = 1'b0;
		while (in_flight) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic pulse_fence();
		int k;
		@(posedge clock);
		#1;
		fetch_fence = 1'b1;
		@(posedge clock);
		#1;
		fetch_fence = 1'b0;
		for (k = 0; k < cache_lines; k++)
			model_valid[k] = 1'b0;
		repeat (2) @(posedge clock);  // let the fence state pass
	endtask

	// compare process sampling on the falling edge
	always @(negedge clock) begin
		if (reset === 1'b0) begin
			if (mem_sel === 1'b1 && !sel_seen) begin
				bursts = bursts + 1;
				check_addr(mem_addr, {pend_addr, 2'b00} & ~32'h7, "burst address");
				check_len(mem_len, burst_len_t'(1), "burst length");
				check_size(mem_size, size_word, "burst size");
			end
			sel_seen = (mem_sel === 1'b1);
			if (fetch_ready === 1'b1) begin
				if (!in_flight)
					abort_run("fetch_ready pulsed while no fetch was outstanding");
				if (bursts > 1)
					abort_run("a single miss started more than one memory burst");
				check_hit(bursts == 0, pend_hit, "hit/miss");
				check_instr(fetch_data, mem_word({pend_addr, 2'b00}), "fetch data");
				if (pend_hit)
					check_latency(cycle_count - strobe_cycle, 2, "hit latency");
				in_flight = 1'b0;
			end
		end
	end

	initial begin
		#(watchdog_time);
		abort_run($sformatf("timeout: the fetch tests did not finish within %0d time units",
			watchdog_time));
	end

	initial begin
		int i;
		fetch_valid = 1'b0;
		fetch_addr  = '0;
		fetch_fence = 1'b0;
		@(posedge clock);
		while (reset !== 1'b0)
			@(posedge clock);
		repeat (2) @(posedge clock);

		for (i = 0; i < cache_lines; i++)
			do_fetch(line_a + word_addr_t'(2 * i));      // cold misses
		for (i = 0; i < cache_lines; i++)
			do_fetch(line_a + word_addr_t'(2 * i));      // hits
		for (i = 0; i < cache_lines; i++)
			do_fetch(line_a + word_addr_t'(2 * i + 1));  // second word, beat 1

		// index 2 shared by two tags
		do_fetch(line_b + 4);
		do_fetch(line_a + 4);
		do_fetch(line_b + 5);
		do_fetch(line_a + 5);

		pulse_fence();
		for (i = 0; i < cache_lines; i++)
			do_fetch(line_a + word_addr_t'(2 * i + 1));

		// fence lands during the refill and must wait for it
		fork
			do_fetch(line_b);
			begin
				do begin
					@(posedge clock);
					#1;
				end while (mem_sel !== 1'b1);
				pulse_fence();
			end
		join
		do_fetch(line_b);
		do_fetch(line_a + 2);

		for (i = 0; i < random_fetches; i++)
			do_fetch(line_c | word_addr_t'(rand_bits(5)));  // 2 tag, 2 index, 1 offset bits

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- bench/tb_memory.sv
// ================================================
// burst DRAM model with random gaps before each beat
// the word at byte address a holds a xor 5A5A0000
// ================================================
module tb_memory (
	input  logic                clock,
	input  logic                reset,
	input  logic                mem_sel,
	input  bus_pkg::byte_addr_t mem_addr,
	input  bus_pkg::burst_len_t mem_len,
	output logic                mem_rvalid,
	output logic                mem_rlast,
	output bus_pkg::beat_t      mem_rdata
);
	import bus_pkg::*;

	logic [15:0] lfsr = 16'd54412;

	// galois step with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_bit();
		logic out;
		out  = lfsr[0];
		lfsr = lfsr >> 1;
		if (out)
			lfsr = lfsr ^ 16'hB400;
		return out;
	endfunction

	task automatic serve_burst();
		byte_addr_t base;
		int         beats;
		int         gap;
		int         i;
		base  = mem_addr;
		beats = int'(mem_len) + 1;
		for (i = 0; i < beats; i++) begin
			gap = {lfsr_bit(), lfsr_bit()};  // 0 to 3 idle cycles
			repeat (gap) begin
				@(posedge clock);
				#1;
			end
			mem_rvalid = 1'b1;
			mem_rlast  = (i == beats - 1);
			mem_rdata  = (base + byte_addr_t'(4 * i)) ^ 32'h5A5A0000;
			@(posedge clock);
			#1;
			mem_rvalid = 1'b0;
			mem_rlast  = 1'b0;
		end
	endtask

	initial begin
		mem_rvalid = 1'b0;
		mem_rlast  = 1'b0;
		mem_rdata  = '0;
		forever begin
			@(posedge clock);
			#1;
			if (reset === 1'b0 && mem_sel === 1'b1)
				serve_burst();  // sel has dropped again on return
		end
	end

endmodule

//--- build.f
hdl/cache_pkg.sv
hdl/bus_pkg.sv
hdl/fetch_port.sv
hdl/icache_core.sv
hdl/line_refill.sv
hdl/fetch_subsystem.sv
bench/tb_clock.sv
bench/tb_memory.sv
bench/tb_fetch.sv

//--- hdl/bus_pkg.sv
// ================================================
// burst read bus towards DRAM
// ================================================
package bus_pkg;

	typedef logic [31:0] byte_addr_t;
	typedef logic [7:0]  burst_len_t;   // beats minus one
	typedef logic [2:0]  burst_size_t;  // log2 of bytes per beat
	typedef logic [31:0] beat_t;

	localparam burst_size_t size_word = 3'b010;  // 4 bytes

	// one beat per instruction word of a line
	localparam burst_len_t refill_len = burst_len_t'(cache_pkg::words_per_line - 1);

endpackage

//--- hdl/cache_pkg.sv
// ================================================
// cache geometry of the direct-mapped icache
// address split, line layout and control states
// ================================================
package cache_pkg;

	localparam int addr_bits      = 30;  // word addresses
	localparam int word_bits      = 32;
	localparam int cache_lines    = 4;
	localparam int words_per_line = 2;

	localparam int idx_bits  = $clog2(cache_lines);
	localparam int off_bits  = $clog2(words_per_line);
	localparam int tag_bits  = addr_bits - idx_bits - off_bits;
	localparam int line_bits = words_per_line * word_bits;

	typedef logic [addr_bits-1:0] word_addr_t;
	typedef logic [idx_bits-1:0]  line_idx_t;   // address bits 2..1
	typedef logic [off_bits-1:0]  word_off_t;   // address bit 0
	typedef logic [tag_bits-1:0]  tag_t;        // address bits 29..3
	typedef logic [line_bits-1:0] line_t;       // word 0 in the low half
	typedef logic [word_bits-1:0] instr_t;

	// icache control states
	typedef enum logic [1:0] {
		idle,
		check,  // tag compare
		load,   // waiting for the refill
		fence   // drop all valid bits
	} cache_state_t;

endpackage

//--- hdl/fetch_port.sv
// ================================================
// fetch port taking core strobes and fence pulses
// and handing them to the icache one at a time
// ================================================
module fetch_port (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  fetch_valid,
	input  cache_pkg::word_addr_t fetch_addr,
	input  logic                  fetch_fence,
	input  logic                  busy,
	output logic                  req_valid,
	output cache_pkg::word_addr_t req_addr,
	output logic                  fence_go
);
	import cache_pkg::*;

	logic req_pend;    // fetch waiting for the cache
	logic fence_pend;  // fence waiting for the cache

	// requests only go out while the cache sits idle
	assign req_valid = req_pend & ~busy;
	assign fence_go  = fence_pend & ~busy & ~req_pend;  // a fetch goes first

	// address is held until the next strobe
	always_ff @(posedge clock) begin
		if (fetch_valid)
			req_addr <= fetch_addr;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			req_pend   <= 1'b0;
			fence_pend <= 1'b0;
		end else begin
			if (fetch_valid)
				req_pend <= 1'b1;
			else if (req_valid)
				req_pend <= 1'b0;

			// a fence during a refill waits here
			if (fetch_fence)
				fence_pend <= 1'b1;
			else if (fence_go)
				fence_pend <= 1'b0;
		end
	end

endmodule

//--- hdl/fetch_subsystem.sv
// ================================================
// instruction fetch path: fetch port, icache core
// and line refill engine
// ================================================
module fetch_subsystem (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  fetch_valid,
	input  cache_pkg::word_addr_t fetch_addr,
	input  logic                  fetch_fence,
	output logic                  fetch_ready,
	output cache_pkg::instr_t     fetch_data,
	output logic                  mem_sel,
	output bus_pkg::byte_addr_t   mem_addr,
	output bus_pkg::burst_len_t   mem_len,
	output bus_pkg::burst_size_t  mem_size,
	input  logic                  mem_rvalid,
	input  logic                  mem_rlast,
	input  bus_pkg::beat_t        mem_rdata
);
	import cache_pkg::*;

	logic       req_valid;
	word_addr_t req_addr;
	logic       fence_go;
	logic       busy;
	logic       refill_start;
	word_addr_t refill_addr;
	logic       line_done;
	line_t      line_data;

	fetch_port u_port (
		.clock       (clock),
		.reset       (reset),
		.fetch_valid (fetch_valid),
		.fetch_addr  (fetch_addr),
		.fetch_fence (fetch_fence),
		.busy        (busy),
		.req_valid   (req_valid),
		.req_addr    (req_addr),
		.fence_go    (fence_go)
	);

	icache_core u_core (
		.clock        (clock),
		.reset        (reset),
		.req_valid    (req_valid),
		.req_addr     (req_addr),
		.fence_go     (fence_go),
		.line_done    (line_done),
		.line_data    (line_data),
		.busy         (busy),
		.fetch_ready  (fetch_ready),
		.fetch_data   (fetch_data),
		.refill_start (refill_start),
		.refill_addr  (refill_addr)
	);

	line_refill u_refill (
		.clock        (clock),
		.reset        (reset),
		.refill_start (refill_start),
		.refill_addr  (refill_addr),
		.mem_rvalid   (mem_rvalid),
		.mem_rlast    (mem_rlast),
		.mem_rdata    (mem_rdata),
		.mem_sel      (mem_sel),
		.mem_addr     (mem_addr),
		.mem_len      (mem_len),
		.mem_size     (mem_size),
		.line_done    (line_done),
		.line_data    (line_data)
	);

endmodule

//--- hdl/icache_core.sv
// ================================================
// icache core with tags, valid bits, line storage,
// hit check and the control FSM
// ================================================
module icache_core (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  req_valid,
	input  cache_pkg::word_addr_t req_addr,
	input  logic                  fence_go,
	input  logic                  line_done,
	input  cache_pkg::line_t      line_data,
	output logic                  busy,
	output logic                  fetch_ready,
	output cache_pkg::instr_t     fetch_data,
	output logic                  refill_start,
	output cache_pkg::word_addr_t refill_addr
);
	import cache_pkg::*;

	cache_state_t state;
	cache_state_t state_next;

	tag_t  tags  [cache_lines];
	line_t lines [cache_lines];
	logic [cache_lines-1:0] valid;

	tag_t      req_tag;
	line_idx_t req_idx;
	word_off_t req_off;
	logic      hit;
	logic      miss_ready;  // refilled word is readable

	assign {req_tag, req_idx, req_off} = req_addr;

	assign hit = valid[req_idx] && (tags[req_idx] == req_tag);

	assign busy = (state != idle);

	// refills are always whole lines
	assign refill_addr = {req_tag, req_idx, {off_bits{1'b0}}};

	// word select from the stored line
	assign fetch_data = lines[req_idx][req_off*word_bits +: word_bits];

	assign fetch_ready = ((state == check) && hit) || miss_ready;

	always_ff @(posedge clock) begin
		if (reset)
			state <= idle;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			idle: begin
				if (req_valid)
					state_next = check;
				else if (fence_go)
					state_next = fence;
			end
			check: begin
				if (hit)
					state_next = idle;
				else
					state_next = load;
			end
			load: begin
				if (line_done)   // memory speed sets the stay here
					state_next = idle;
			end
			fence: begin
				state_next = idle;
			end
			default: state_next = idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			refill_start <= 1'b0;
			miss_ready   <= 1'b0;
		end else begin
			refill_start <= (state == check) && !hit;  // first load cycle
			miss_ready   <= (state == load) && line_done;
		end
	end

	// line and tag written when the refill ends
	always_ff @(posedge clock) begin
		if ((state == load) && line_done) begin
			lines[req_idx] <= line_data;
			tags[req_idx]  <= req_tag;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
		end else if (state == fence) begin
			valid <= '0;  // fence.i drops every line at once
		end else if ((state == load) && line_done) begin
			valid[req_idx] <= 1'b1;
		end
	end

endmodule

//--- hdl/line_refill.sv
// ================================================
// line refill engine issuing one read burst per miss
// and shifting the beats into a full cache line
// ================================================
module line_refill (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  refill_start,
	input  cache_pkg::word_addr_t refill_addr,
	input  logic                  mem_rvalid,
	input  logic                  mem_rlast,
	input  bus_pkg::beat_t        mem_rdata,
	output logic                  mem_sel,
	output bus_pkg::byte_addr_t   mem_addr,
	output bus_pkg::burst_len_t   mem_len,
	output bus_pkg::burst_size_t  mem_size,
	output logic                  line_done,
	output cache_pkg::line_t      line_data
);
	import cache_pkg::*;
	import bus_pkg::*;

	line_t line_q;
	logic  beat;  // a beat of our burst
	logic  last;

	assign beat = mem_sel & mem_rvalid;
	assign last = beat & mem_rlast;

	assign mem_len   = refill_len;  // whole line in word beats
	assign mem_size  = size_word;
	assign line_data = line_q;

	// byte address held for the whole burst
	always_ff @(posedge clock) begin
		if (refill_start)
			mem_addr <= {refill_addr, 2'b00};
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			mem_sel   <= 1'b0;
			line_done <= 1'b0;
		end else begin
			if (refill_start)
				mem_sel <= 1'b1;
			else if (last)
				mem_sel <= 1'b0;   // drop after the final beat
			line_done <= last;
		end
	end

	// new beat enters at the top, so beat 0 ends up as word 0
	always_ff @(posedge clock) begin
		if (beat)
			line_q <= {mem_rdata, line_q[$bits(line_t)-1:$bits(beat_t)]};
	end

endmodule
